/* rtl/i2c_tx_pkg.sv */
package i2c_tx_pkg;

    // shifter FSM states, one clk_load/clk_low/clk_high walk per bit
    typedef enum logic [2:0] {
        TX_IDLE     = 3'd0,
        TX_CLK_LOAD = 3'd1,
        TX_CLK_LOW  = 3'd2,
        TX_CLK_HIGH = 3'd3,
        TX_DONE     = 3'd4
    } tx_state_t;

    localparam int BITS_PER_BYTE = 8;

    // counts the data bits down to zero, and zero is the acknowledge slot
    typedef logic [3:0] bit_cnt_t;

    // width of the SCL phase timer
    localparam int CNT_W = 16;

    localparam int APB_ADDR_W = 4;

    // register byte offsets on the APB side
    localparam logic [APB_ADDR_W-1:0] REG_TAR    = 4'h0;
    localparam logic [APB_ADDR_W-1:0] REG_DATA   = 4'h4;
    localparam logic [APB_ADDR_W-1:0] REG_CMD    = 4'h8;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 4'hC;

    // open-drain enables are active low, so a one lets the pull-up win
    localparam logic LINE_RELEASED = 1'b1;

endpackage

/* rtl/i2c_tx_apb_regs.sv */
`timescale 1ns/1ps

module i2c_tx_apb_regs (
    input  logic                                i2c_clk,
    input  logic                                i2c_rst_n,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [i2c_tx_pkg::APB_ADDR_W-1:0]   paddr,
    input  logic [31:0]                         pwdata,
    input  logic                                busy,
    input  logic                                byte_done,
    input  logic                                nack,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                start,
    output logic [6:0]                          tar,
    output logic [7:0]                          tx_data,
    output logic                                addr_phase,
    output logic                                rw
);

    logic wr_access;
    logic cmd_start;
    logic start_reject;
    logic start_accept;
    logic done_flag;
    logic nack_flag;

    // no wait states on this bus
    assign pready = 1'b1;

    assign wr_access = psel & penable & pwrite;
    assign cmd_start = wr_access & (paddr == i2c_tx_pkg::REG_CMD) & pwdata[0];

    // a start pulse still in flight counts as busy as well
    assign start_reject = cmd_start & (busy | start);
    assign start_accept = cmd_start & ~start_reject;

    assign pslverr = start_reject;

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            tar     <= 7'h00;
            tx_data <= 8'h00;
        end else if (wr_access) begin
            if (paddr == i2c_tx_pkg::REG_TAR) begin
                tar <= pwdata[6:0];
            end
            if (paddr == i2c_tx_pkg::REG_DATA) begin
                tx_data <= pwdata[7:0];
            end
        end
    end

    // command bits are taken only together with an accepted start
    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            start      <= 1'b0;
            addr_phase <= 1'b0;
            rw         <= 1'b0;
        end else begin
            start <= start_accept;
            if (start_accept) begin
                addr_phase <= pwdata[1];
                rw         <= pwdata[2];
            end
        end
    end

    // done stays set until software launches the next byte
    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            done_flag <= 1'b0;
            nack_flag <= 1'b0;
        end else begin
            if (start_accept) begin
                done_flag <= 1'b0;
            end else if (byte_done) begin
                done_flag <= 1'b1;
            end
            if (byte_done) begin
                nack_flag <= nack;
            end
        end
    end

    always_comb begin
        prdata = 32'h0000_0000;
        case (paddr)
            i2c_tx_pkg::REG_TAR: begin
                prdata[6:0] = tar;
            end
            i2c_tx_pkg::REG_DATA: begin
                prdata[7:0] = tx_data;
            end
            i2c_tx_pkg::REG_STATUS: begin
                prdata[2:0] = {done_flag, nack_flag, busy};
            end
            // CMD is write-only and reads back as zero
            default: begin
                prdata = 32'h0000_0000;
            end
        endcase
    end

endmodule

/* rtl/i2c_tx_bit_shifter.sv */
`timescale 1ns/1ps

module i2c_tx_bit_shifter (
    input  logic        i2c_clk,
    input  logic        i2c_rst_n,
    input  logic        start,
    input  logic [6:0]  tar,
    input  logic [7:0]  tx_data,
    input  logic        addr_phase,
    input  logic        rw,
    input  logic        scl_in,
    input  logic        sda_in,
    input  logic        low_complete,
    input  logic        high_complete,
    output logic        busy,
    output logic        byte_done,
    output logic        nack,
    output logic        load_low,
    output logic        load_high,
    output logic        high_cnt_en,
    output logic        scl_oe_n,
    output logic        sda_oe_n
);

    i2c_tx_pkg::tx_state_t state;
    i2c_tx_pkg::tx_state_t nx_state;
    i2c_tx_pkg::bit_cnt_t  bit_cnt;

    logic [7:0] shift_byte;
    logic [2:0] bit_idx;
    logic       take_start;
    logic       ack_slot;
    logic       arc_high_load;
    logic       done_gen;
    logic       done_gen_dly;

    assign busy = (state != i2c_tx_pkg::TX_IDLE) & (state != i2c_tx_pkg::TX_DONE);

    assign take_start    = start & ~busy;
    assign ack_slot      = (bit_cnt == '0);
    assign arc_high_load = (state == i2c_tx_pkg::TX_CLK_HIGH) &
                           (nx_state == i2c_tx_pkg::TX_CLK_LOAD);

    // a count of 8 wraps to index 7, so the MSB goes out first
    assign bit_idx = bit_cnt[2:0] - 3'd1;

    // the timer is loaded on the arc into each phase so that phase lengths match the counts
    assign load_low  = (nx_state == i2c_tx_pkg::TX_CLK_LOAD);
    assign load_high = (nx_state == i2c_tx_pkg::TX_CLK_HIGH) &
                       (state != i2c_tx_pkg::TX_CLK_HIGH);

    // a slave stretching SCL freezes the high phase count
    assign high_cnt_en = (state == i2c_tx_pkg::TX_CLK_HIGH) & scl_in;

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            state <= i2c_tx_pkg::TX_IDLE;
        end else begin
            state <= nx_state;
        end
    end

    always_comb begin
        nx_state = state;
        case (state)
            i2c_tx_pkg::TX_IDLE: begin
                if (start) begin
                    nx_state = i2c_tx_pkg::TX_CLK_LOAD;
                end
            end
            i2c_tx_pkg::TX_CLK_LOAD: begin
                nx_state = i2c_tx_pkg::TX_CLK_LOW;
            end
            i2c_tx_pkg::TX_CLK_LOW: begin
                if (low_complete) begin
                    nx_state = i2c_tx_pkg::TX_CLK_HIGH;
                end
            end
            i2c_tx_pkg::TX_CLK_HIGH: begin
                if (high_complete && ack_slot) begin
                    nx_state = i2c_tx_pkg::TX_DONE;
                end else if (high_complete) begin
                    nx_state = i2c_tx_pkg::TX_CLK_LOAD;
                end
            end
            i2c_tx_pkg::TX_DONE: begin
                nx_state = start ? i2c_tx_pkg::TX_CLK_LOAD : i2c_tx_pkg::TX_IDLE;
            end
            default: begin
                nx_state = i2c_tx_pkg::TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            bit_cnt <= i2c_tx_pkg::bit_cnt_t'(i2c_tx_pkg::BITS_PER_BYTE);
        end else if (take_start) begin
            bit_cnt <= i2c_tx_pkg::bit_cnt_t'(i2c_tx_pkg::BITS_PER_BYTE);
        end else if (arc_high_load) begin
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    // address byte is the 7-bit target with the read/write bit last
    always_ff @(posedge i2c_clk) begin
        if (take_start) begin
            shift_byte <= addr_phase ? {tar, rw} : tx_data;
        end
    end

    // acknowledge is taken at the end of the ninth high phase
    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            nack <= 1'b0;
        end else if ((state == i2c_tx_pkg::TX_CLK_HIGH) && high_complete && ack_slot) begin
            nack <= sda_in;
        end
    end

    // pin drive follows the next state, SDA only moves one cycle into the low phase
    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            scl_oe_n <= i2c_tx_pkg::LINE_RELEASED;
            sda_oe_n <= i2c_tx_pkg::LINE_RELEASED;
            done_gen <= 1'b0;
        end else begin
            case (nx_state)
                i2c_tx_pkg::TX_CLK_LOAD: begin
                    scl_oe_n <= ~i2c_tx_pkg::LINE_RELEASED;
                    done_gen <= 1'b0;
                end
                i2c_tx_pkg::TX_CLK_LOW: begin
                    scl_oe_n <= ~i2c_tx_pkg::LINE_RELEASED;
                    done_gen <= 1'b0;
                    if (ack_slot) begin
                        sda_oe_n <= i2c_tx_pkg::LINE_RELEASED;
                    end else if (shift_byte[bit_idx]) begin
                        sda_oe_n <= i2c_tx_pkg::LINE_RELEASED;
                    end else begin
                        sda_oe_n <= ~i2c_tx_pkg::LINE_RELEASED;
                    end
                end
                i2c_tx_pkg::TX_CLK_HIGH: begin
                    scl_oe_n <= i2c_tx_pkg::LINE_RELEASED;
                    done_gen <= 1'b0;
                end
                i2c_tx_pkg::TX_DONE: begin
                    scl_oe_n <= i2c_tx_pkg::LINE_RELEASED;
                    sda_oe_n <= i2c_tx_pkg::LINE_RELEASED;
                    done_gen <= 1'b1;
                end
                default: begin
                    scl_oe_n <= i2c_tx_pkg::LINE_RELEASED;
                    sda_oe_n <= i2c_tx_pkg::LINE_RELEASED;
                    done_gen <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            done_gen_dly <= 1'b0;
        end else begin
            done_gen_dly <= done_gen;
        end
    end

    // rising edge of done_gen, one cycle wide
    assign byte_done = done_gen & ~done_gen_dly;

endmodule

/* rtl/i2c_tx_scl_timer.sv */
`timescale 1ns/1ps

module i2c_tx_scl_timer #(
    parameter int SCL_LOW_CNT  = 250,
    parameter int SCL_HIGH_CNT = 250
) (
    input  logic i2c_clk,
    input  logic i2c_rst_n,
    input  logic load_low,
    input  logic load_high,
    input  logic high_cnt_en,
    output logic low_complete,
    output logic high_complete
);

    typedef logic [i2c_tx_pkg::CNT_W-1:0] cnt_t;

    // reaching zero is itself a counted cycle, hence the minus one
    localparam cnt_t LOW_LOAD  = cnt_t'(SCL_LOW_CNT - 1);
    localparam cnt_t HIGH_LOAD = cnt_t'(SCL_HIGH_CNT - 1);

    cnt_t cnt;
    logic phase_high;
    logic active;
    logic tick;
    logic at_zero;

    // the high phase only advances while the enable says SCL is really high
    assign tick    = active & (~phase_high | high_cnt_en);
    assign at_zero = (cnt == '0);

    assign low_complete  = tick & ~phase_high & at_zero;
    assign high_complete = tick & phase_high & at_zero;

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            cnt        <= '0;
            phase_high <= 1'b0;
            active     <= 1'b0;
        end else if (load_low) begin
            cnt        <= LOW_LOAD;
            phase_high <= 1'b0;
            active     <= 1'b1;
        end else if (load_high) begin
            cnt        <= HIGH_LOAD;
            phase_high <= 1'b1;
            active     <= 1'b1;
        end else if (tick) begin
            if (at_zero) begin
                // stop here so the complete output stays a single pulse
                active <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

/* rtl/i2c_tx_top.sv */
`timescale 1ns/1ps

module i2c_tx_top #(
    parameter int SCL_LOW_CNT  = 250,
    parameter int SCL_HIGH_CNT = 250
) (
    input  logic                                i2c_clk,
    input  logic                                i2c_rst_n,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [i2c_tx_pkg::APB_ADDR_W-1:0]   paddr,
    input  logic [31:0]                         pwdata,
    input  logic                                scl_in,
    input  logic                                sda_in,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                scl_oe_n,
    output logic                                sda_oe_n,
    output logic                                done_irq
);

    logic       start;
    logic [6:0] tar;
    logic [7:0] tx_data;
    logic       addr_phase;
    logic       rw;
    logic       busy;
    logic       nack;
    logic       load_low;
    logic       load_high;
    logic       high_cnt_en;
    logic       low_complete;
    logic       high_complete;

    // register block, the byte done pulse doubles as the interrupt
    i2c_tx_apb_regs u_regs (
        .i2c_clk    (i2c_clk),
        .i2c_rst_n  (i2c_rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .busy       (busy),
        .byte_done  (done_irq),
        .nack       (nack),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .start      (start),
        .tar        (tar),
        .tx_data    (tx_data),
        .addr_phase (addr_phase),
        .rw         (rw)
    );

    i2c_tx_bit_shifter u_shifter (
        .i2c_clk       (i2c_clk),
        .i2c_rst_n     (i2c_rst_n),
        .start         (start),
        .tar           (tar),
        .tx_data       (tx_data),
        .addr_phase    (addr_phase),
        .rw            (rw),
        .scl_in        (scl_in),
        .sda_in        (sda_in),
        .low_complete  (low_complete),
        .high_complete (high_complete),
        .busy          (busy),
        .byte_done     (done_irq),
        .nack          (nack),
        .load_low      (load_low),
        .load_high     (load_high),
        .high_cnt_en   (high_cnt_en),
        .scl_oe_n      (scl_oe_n),
        .sda_oe_n      (sda_oe_n)
    );

    i2c_tx_scl_timer #(
        .SCL_LOW_CNT  (SCL_LOW_CNT),
        .SCL_HIGH_CNT (SCL_HIGH_CNT)
    ) u_timer (
        .i2c_clk       (i2c_clk),
        .i2c_rst_n     (i2c_rst_n),
        .load_low      (load_low),
        .load_high     (load_high),
        .high_cnt_en   (high_cnt_en),
        .low_complete  (low_complete),
        .high_complete (high_complete)
    );

endmodule

/* testbench/i2c_tx_sva.sv */
`timescale 1ns/1ps

module i2c_tx_sva (
    input logic i2c_clk,
    input logic i2c_rst_n,
    input logic start,
    input logic busy,
    input logic byte_done,
    input logic scl_in,
    input logic scl_oe_n,
    input logic sda_oe_n
);

    // the data line only moves while SCL is low
    property sda_stable_while_scl_high;
        @(posedge i2c_clk) disable iff (!i2c_rst_n)
        (busy && scl_oe_n && scl_in) |=> $stable(sda_oe_n);
    endproperty

    // the done pulse marks the cycle where busy drops and is gone the cycle after
    property done_single_cycle;
        @(posedge i2c_clk) disable iff (!i2c_rst_n)
        byte_done |-> $fell(busy) ##1 !byte_done;
    endproperty

    // an idle shifter stays idle until a start pulse arrives
    property busy_only_after_start;
        @(posedge i2c_clk) disable iff (!i2c_rst_n)
        (!busy && !start) |=> !busy;
    endproperty

    assert property (sda_stable_while_scl_high)
        else $error("sda_oe_n changed while SCL was high during a transfer");

    assert property (done_single_cycle)
        else $error("byte_done was not a single pulse at the fall of busy");

    assert property (busy_only_after_start)
        else $error("busy rose without a start pulse");

endmodule

bind i2c_tx_bit_shifter i2c_tx_sva sva_i (
    .i2c_clk   (i2c_clk),
    .i2c_rst_n (i2c_rst_n),
    .start     (start),
    .busy      (busy),
    .byte_done (byte_done),
    .scl_in    (scl_in),
    .scl_oe_n  (scl_oe_n),
    .sda_oe_n  (sda_oe_n)
);

/* testbench/i2c_tx_tb.sv */
`timescale 1ns/1ps

module i2c_tx_tb;

    localparam int SCL_LOW_CNT  = 5;
    localparam int SCL_HIGH_CNT = 4;
    localparam int CLK_PERIOD   = 20;
    localparam int NUM_XFERS    = 24;
    localparam int MIN_XFER     = 9 * (SCL_LOW_CNT + SCL_HIGH_CNT);
    localparam int WATCHDOG_CYC = NUM_XFERS * (9 * 9 + 40) + 200;

    logic                              i2c_clk;
    logic                              i2c_rst_n;
    logic                              psel;
    logic                              penable;
    logic                              pwrite;
    logic [i2c_tx_pkg::APB_ADDR_W-1:0] paddr;
    logic [31:0]                       pwdata;
    logic                              scl_in;
    logic                              sda_in;
    logic [31:0]                       prdata;
    logic                              pready;
    logic                              pslverr;
    logic                              scl_oe_n;
    logic                              sda_oe_n;
    logic                              done_irq;

    // bus model state, the slave side of the wired-AND lines
    logic [31:0] rng;
    logic        slave_sda;
    logic        ack_level;
    logic        ack_released;
    logic        scl_oe_prev;
    logic [7:0]  rx_byte;
    int          bit_seen;
    int          stretch_left;
    int          stretch_plan [0:8];
    int          cycle_cnt = 0;
    int          errors = 0;
    int          rejects = 0;
    int          stretch_total = 0;

    i2c_tx_top #(
        .SCL_LOW_CNT  (SCL_LOW_CNT),
        .SCL_HIGH_CNT (SCL_HIGH_CNT)
    ) dut_i (
        .i2c_clk   (i2c_clk),
        .i2c_rst_n (i2c_rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .scl_oe_n  (scl_oe_n),
        .sda_oe_n  (sda_oe_n),
        .done_irq  (done_irq)
    );

    initial i2c_clk = 1'b0;
    always #(CLK_PERIOD / 2) i2c_clk = ~i2c_clk;

    always @(posedge i2c_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge i2c_clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge i2c_clk);
        #2;
        penable = 1'b1;
        #1;
        err = pslverr;
        if (pready !== 1'b1) begin
            report_mismatch("pready", pready, 1);
        end
        @(posedge i2c_clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge i2c_clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge i2c_clk);
        #2;
        penable = 1'b1;
        #1;
        data = prdata;
        @(posedge i2c_clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic record_rise();
        scl_in = 1'b1;
        if (bit_seen < 8) begin
            rx_byte = {rx_byte[6:0], sda_oe_n & slave_sda};
        end else begin
            ack_released = sda_oe_n;
        end
        bit_seen++;
    endtask

    // slave model: follows SCL with optional stretch, drives the acknowledge slot
    always @(posedge i2c_clk) begin
        #2;
        if (done_irq) begin
            slave_sda = 1'b1;
        end
        if (!scl_oe_n) begin
            if (scl_in) begin
                if (bit_seen == 9) begin
                    bit_seen = 0;
                end
                if (bit_seen == 8) begin
                    slave_sda = ack_level;
                end
            end
            scl_in       = 1'b0;
            stretch_left = 0;
        end else if (!scl_oe_prev) begin
            if (stretch_plan[bit_seen] > 0) begin
                stretch_left = stretch_plan[bit_seen];
            end else begin
                record_rise();
            end
        end else if (stretch_left > 0) begin
            stretch_left--;
            if (stretch_left == 0) begin
                record_rise();
            end
        end
        scl_oe_prev = scl_oe_n;
        sda_in      = sda_oe_n & slave_sda;
    end

    task automatic run_transfer(input int idx);
        logic [6:0]  t;
        logic [7:0]  d;
        logic [7:0]  exp_byte;
        logic [31:0] rdata;
        logic        a_ph;
        logic        r_w;
        logic        stretchy;
        logic        err;
        int          stretch_sum;
        int          t0;
        int          elapsed;
        rng      = xorshift32(rng);
        t        = rng[6:0];
        d        = rng[15:8];
        a_ph     = rng[16];
        r_w      = rng[17];
        stretchy = rng[19];
        ack_level = rng[18];
        stretch_sum = 0;
        for (int i = 0; i < 9; i++) begin
            rng = xorshift32(rng);
            stretch_plan[i] = stretchy ? int'(rng % 3) : 0;
            stretch_sum += stretch_plan[i];
        end
        stretch_total += stretch_sum;
        exp_byte = a_ph ? {t, r_w} : d;
        apb_write(i2c_tx_pkg::REG_TAR, {25'd0, t}, err);
        apb_write(i2c_tx_pkg::REG_DATA, {24'd0, d}, err);
        apb_write(i2c_tx_pkg::REG_CMD, {29'd0, r_w, a_ph, 1'b1}, err);
        t0 = cycle_cnt;
        if (err !== 1'b0) begin
            report_mismatch("pslverr", err, 0);
        end
        // a second start while busy must bounce and leave the byte alone
        if (idx % 3 == 2) begin
            rejects++;
            repeat (6) @(posedge i2c_clk);
            #2;
            apb_write(i2c_tx_pkg::REG_DATA, {24'd0, ~d}, err);
            apb_write(i2c_tx_pkg::REG_CMD, {29'd0, ~r_w, ~a_ph, 1'b1}, err);
            if (err !== 1'b1) begin
                report_mismatch("pslverr", err, 1);
            end
        end
        while (done_irq !== 1'b1 && cycle_cnt - t0 < MIN_XFER + stretch_sum + 20) begin
            @(posedge i2c_clk);
            #2;
        end
        elapsed = cycle_cnt - t0;
        if (done_irq !== 1'b1) begin
            report_failure($sformatf("done_irq did not rise within %0d cycles", elapsed));
        end else if (elapsed < MIN_XFER || elapsed > MIN_XFER + stretch_sum + 4) begin
            report_failure($sformatf("transfer took %0d cycles, allowed %0d to %0d",
                                     elapsed, MIN_XFER, MIN_XFER + stretch_sum + 4));
        end
        if (bit_seen != 9) begin
            report_mismatch("scl rising edges", bit_seen, 9);
        end
        if (rx_byte !== exp_byte) begin
            report_mismatch("sda byte", rx_byte, exp_byte);
        end
        if (ack_released !== 1'b1) begin
            report_mismatch("sda_oe_n in ack slot", ack_released, 1);
        end
        apb_read(i2c_tx_pkg::REG_STATUS, rdata);
        if (rdata !== {29'd0, 1'b1, ack_level, 1'b0}) begin
            report_mismatch("status", rdata, {29'd0, 1'b1, ack_level, 1'b0});
        end
    endtask

    initial begin
        logic [31:0] rdata;
        i2c_rst_n    = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        scl_in       = 1'b1;
        sda_in       = 1'b1;
        slave_sda    = 1'b1;
        ack_level    = 1'b0;
        ack_released = 1'b0;
        scl_oe_prev  = 1'b1;
        rx_byte      = '0;
        bit_seen     = 0;
        stretch_left = 0;
        rng          = 32'd79004;
        for (int i = 0; i < 9; i++) begin
            stretch_plan[i] = 0;
        end
        repeat (10) @(posedge i2c_clk);
        #2;
        i2c_rst_n = 1'b1;
        if (scl_oe_n !== 1'b1) begin
            report_mismatch("scl_oe_n", scl_oe_n, 1);
        end
        if (sda_oe_n !== 1'b1) begin
            report_mismatch("sda_oe_n", sda_oe_n, 1);
        end
        if (done_irq !== 1'b0) begin
            report_mismatch("done_irq", done_irq, 0);
        end
        if (pslverr !== 1'b0) begin
            report_mismatch("pslverr", pslverr, 0);
        end
        apb_read(i2c_tx_pkg::REG_STATUS, rdata);
        if (rdata !== 32'd0) begin
            report_mismatch("status", rdata, 0);
        end
        for (int x = 0; x < NUM_XFERS; x++) begin
            run_transfer(x);
        end
        $display("Summary: %0d transfers, %0d rejected starts, %0d stretch cycles, %0d errors",
                 NUM_XFERS, rejects, stretch_total, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Error: watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYC);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* i2c_tx_top.f */
rtl/i2c_tx_pkg.sv
rtl/i2c_tx_apb_regs.sv
rtl/i2c_tx_bit_shifter.sv
rtl/i2c_tx_scl_timer.sv
rtl/i2c_tx_top.sv
testbench/i2c_tx_sva.sv
testbench/i2c_tx_tb.sv
